// ==== include/rp_consts.svh ====
`ifndef RP_CONSTS_SVH
`define RP_CONSTS_SVH

// Register select codes
`define RP_CS1            3'd0
`define RP_DS             3'd1
`define RP_ER1            3'd2
`define RP_AS             3'd3
`define RP_DA             3'd4
`define RP_DC             3'd5

// Function codes, CS1 bits 5:1
`define RP_FN_NOP         5'd0
`define RP_FN_SEEK        5'd2
`define RP_FN_RECAL       5'd3
`define RP_FN_DRVCLR      5'd4
`define RP_FN_PRESET      5'd8
`define RP_FN_PAKACK      5'd9
`define RP_FN_WRITE       5'd24
`define RP_FN_READ        5'd28

// CS1 bit positions
`define RP_CS1_GO         0
`define RP_CS1_RDY        7

// Pack geometry
`define RP_CYLS           815
`define RP_TRACKS         19
`define RP_SECTORS        20

// Busy times in clocks, and the width of the counter that times them
`define RP_SEEK_CYCLES    40
`define RP_XFER_CYCLES    25
`define RP_CNT_W          6

// Drive status bit positions
`define RP_DS_ATA         15
`define RP_DS_ERR         14
`define RP_DS_PIP         13
`define RP_DS_MOL         12
`define RP_DS_WRL         11
`define RP_DS_LST         10
`define RP_DS_PGM         9
`define RP_DS_DPR         8
`define RP_DS_DRY         7
`define RP_DS_VV          6

// Error register 1 bit positions
`define RP_ER1_ILF        0
`define RP_ER1_RMR        2
`define RP_ER1_IAE        10
`define RP_ER1_WLE        11

`endif

// ==== verilog/rpPkg.sv ====
package rpPkg;

   // Plain register quantities
   typedef logic [15:0] rpWord_t;
   typedef logic [2:0]  rpRegAddr_t;
   typedef logic [4:0]  rpFunc_t;

   // Disk address fields
   typedef logic [9:0]  rpCyl_t;
   typedef logic [4:0]  rpTrack_t;
   typedef logic [4:0]  rpSector_t;

   // Full address, cylinder in the top bits
   typedef struct packed {
      rpCyl_t    cyl;
      rpTrack_t  track;
      rpSector_t sector;
   } rpDiskAddr_t;

   // One-cycle function launch
   typedef struct packed {
      logic    start;
      rpFunc_t func;
   } rpCmd_t;

   // One-cycle error set pulses
   typedef struct packed {
      logic ilf;
      logic iae;
      logic wle;
      logic rmr;
   } rpErrSet_t;

   // Media levels from the pack
   typedef struct packed {
      logic cd;
      logic wp;
   } rpMedia_t;

   // Function sequencer states
   typedef enum logic [1:0] {
      seqIdle,
      seqSeeking,
      seqTransferring,
      seqFinishing
   } rpSeqState_t;

endpackage

// ==== verilog/rpControl.sv ====
`timescale 1ns/1ns
`include "rp_consts.svh"

module rpControl
(
   input  logic               clk,
   input  logic               rst,
   input  logic               clr,
   input  logic               wr,
   input  rpPkg::rpRegAddr_t  wrAddr,
   input  rpPkg::rpWord_t     wrData,
   input  rpPkg::rpRegAddr_t  rdAddr,
   input  logic               dry,
   input  logic               sectorAdvance,
   input  logic               addrClear,
   input  rpPkg::rpWord_t     er1,
   input  rpPkg::rpWord_t     ds,
   output rpPkg::rpWord_t     rdData,
   output rpPkg::rpCmd_t      cmd,
   output rpPkg::rpDiskAddr_t diskAddr,
   output logic               ataClr,
   output logic               daWrite,
   output logic               rmr
);

   rpPkg::rpFunc_t     cs1Func;
   rpPkg::rpDiskAddr_t nextAddr;
   logic               cs1Write;
   logic               dcWrite;
   logic               guarded;
   logic               recalGo;

   ////////////////////////////////////////////////////////////
   // Write decode
   ////////////////////////////////////////////////////////////

   // CS1, DA and DC only change while the drive is ready
   assign guarded  = wrAddr == `RP_CS1 || wrAddr == `RP_DA || wrAddr == `RP_DC;
   assign cs1Write = wr && wrAddr == `RP_CS1 && dry;
   assign daWrite  = wr && wrAddr == `RP_DA && dry;
   assign dcWrite  = wr && wrAddr == `RP_DC && dry;
   assign rmr      = wr && guarded && !dry;

   // Attention is write-one-to-clear
   assign ataClr = wr && wrAddr == `RP_AS && wrData[0];

   // GO launches straight from the write cycle
   assign cmd = '{start: cs1Write && wrData[`RP_CS1_GO], func: wrData[5:1]};

   // Recal takes the heads home
   assign recalGo = cmd.start && cmd.func == `RP_FN_RECAL;

   ////////////////////////////////////////////////////////////
   // Sector advance
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      nextAddr = diskAddr;
      if (diskAddr.sector == `RP_SECTORS - 1)
      begin
         nextAddr.sector = '0;
         // Last sector rolls into the next track
         if (diskAddr.track == `RP_TRACKS - 1)
         begin
            nextAddr.track = '0;
            nextAddr.cyl   = (diskAddr.cyl == `RP_CYLS - 1) ? '0 : diskAddr.cyl + 1'b1;
         end
         else
            nextAddr.track = diskAddr.track + 1'b1;
      end
      else
         nextAddr.sector = diskAddr.sector + 1'b1;
   end

   ////////////////////////////////////////////////////////////
   // CS1 function, DA and DC
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cs1Func  <= '0;
         diskAddr <= '0;
      end
      else
      begin
         if (clr)
            cs1Func <= '0;
         else if (cs1Write)
            cs1Func <= wrData[5:1];

         // Preset wins over everything
         if (addrClear)
            diskAddr <= '0;
         else
         begin
            // DA carries track and sector
            if (daWrite)
            begin
               diskAddr.track  <= wrData[12:8];
               diskAddr.sector <= wrData[4:0];
            end
            else if (sectorAdvance)
            begin
               diskAddr.track  <= nextAddr.track;
               diskAddr.sector <= nextAddr.sector;
            end

            // DC carries the cylinder
            if (recalGo)
               diskAddr.cyl <= '0;
            else if (dcWrite)
               diskAddr.cyl <= wrData[9:0];
            else if (sectorAdvance)
               diskAddr.cyl <= nextAddr.cyl;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Read multiplexer
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      rdData = '0;
      case (rdAddr)
         `RP_CS1:
         begin
            rdData[5:1]         = cs1Func;
            rdData[`RP_CS1_RDY] = dry;
         end
         `RP_DS:  rdData = ds;
         `RP_ER1: rdData = er1;
         // Single drive, so AS is just our attention bit
         `RP_AS:  rdData[0] = ds[`RP_DS_ATA];
         `RP_DA:  rdData = {3'b000, diskAddr.track, 3'b000, diskAddr.sector};
         `RP_DC:  rdData = {6'b000000, diskAddr.cyl};
         default: rdData = '0;
      endcase
   end

endmodule

// ==== verilog/rpSequencer.sv ====
`timescale 1ns/1ns
`include "rp_consts.svh"

module rpSequencer
(
   input  logic               clk,
   input  logic               rst,
   input  logic               clr,
   input  rpPkg::rpCmd_t      cmd,
   input  rpPkg::rpDiskAddr_t diskAddr,
   input  rpPkg::rpMedia_t    media,
   output logic               dry,
   output logic               pip,
   output logic               sectorAdvance,
   output logic               addrClear,
   output logic               setAta,
   output logic               setLst,
   output logic               drvClr,
   output logic               volValid,
   output rpPkg::rpErrSet_t   errSet
);

   rpPkg::rpSeqState_t    state;
   logic [`RP_CNT_W-1:0]  count;
   logic                  positioning;

   logic fnSeek;
   logic fnRecal;
   logic fnRead;
   logic fnWrite;
   logic fnImmediate;
   logic fnLegal;
   logic badAddr;
   logic ilfHit;
   logic iaeHit;
   logic wleHit;

   ////////////////////////////////////////////////////////////
   // Function decode and launch checks
   ////////////////////////////////////////////////////////////

   assign fnSeek      = cmd.func == `RP_FN_SEEK;
   assign fnRecal     = cmd.func == `RP_FN_RECAL;
   assign fnRead      = cmd.func == `RP_FN_READ;
   assign fnWrite     = cmd.func == `RP_FN_WRITE;
   assign fnImmediate = cmd.func == `RP_FN_NOP || cmd.func == `RP_FN_DRVCLR ||
                        cmd.func == `RP_FN_PRESET || cmd.func == `RP_FN_PAKACK;
   assign fnLegal     = fnSeek || fnRecal || fnRead || fnWrite || fnImmediate;

   // Any field at or past its limit
   assign badAddr = diskAddr.cyl >= `RP_CYLS || diskAddr.track >= `RP_TRACKS ||
                    diskAddr.sector >= `RP_SECTORS;

   // Recal ignores DA and DC
   assign ilfHit = !fnLegal;
   assign iaeHit = (fnSeek || fnRead || fnWrite) && badAddr;
   assign wleHit = fnWrite && media.wp;

   // Ready and positioning levels come from the state
   assign dry = state == rpPkg::seqIdle;
   assign pip = state == rpPkg::seqSeeking || (state == rpPkg::seqFinishing && positioning);

   ////////////////////////////////////////////////////////////
   // Function FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state         <= rpPkg::seqIdle;
         count         <= '0;
         positioning   <= 1'b0;
         sectorAdvance <= 1'b0;
         addrClear     <= 1'b0;
         setAta        <= 1'b0;
         setLst        <= 1'b0;
         drvClr        <= 1'b0;
         volValid      <= 1'b0;
         errSet        <= '0;
      end
      else
      begin
         // Every output pulse lasts one clock
         sectorAdvance <= 1'b0;
         addrClear     <= 1'b0;
         setAta        <= 1'b0;
         setLst        <= 1'b0;
         drvClr        <= 1'b0;
         volValid      <= 1'b0;
         errSet        <= '0;

         if (clr)
            state <= rpPkg::seqIdle;
         else
            case (state)
               rpPkg::seqIdle:
                  if (cmd.start)
                  begin
                     errSet.ilf <= ilfHit;
                     errSet.iae <= iaeHit;
                     errSet.wle <= wleHit;
                     // A faulted launch only flags and raises attention
                     if (ilfHit || iaeHit || wleHit)
                        setAta <= 1'b1;
                     else if (fnSeek || fnRecal)
                     begin
                        state       <= rpPkg::seqSeeking;
                        count       <= `RP_CNT_W'(`RP_SEEK_CYCLES - 2);
                        positioning <= 1'b1;
                     end
                     else if (fnRead || fnWrite)
                     begin
                        state       <= rpPkg::seqTransferring;
                        count       <= `RP_CNT_W'(`RP_XFER_CYCLES - 2);
                        positioning <= 1'b0;
                     end
                     else
                     begin
                        // Done in one clock
                        drvClr    <= cmd.func == `RP_FN_DRVCLR;
                        addrClear <= cmd.func == `RP_FN_PRESET;
                        volValid  <= media.cd && (cmd.func == `RP_FN_PRESET ||
                                                  cmd.func == `RP_FN_PAKACK);
                     end
                  end

               rpPkg::seqSeeking, rpPkg::seqTransferring:
               begin
                  count <= count - 1'b1;
                  if (count == '0)
                     state <= rpPkg::seqFinishing;
               end

               // Last busy clock, completion pulses land with dry
               rpPkg::seqFinishing:
               begin
                  state         <= rpPkg::seqIdle;
                  setAta        <= positioning;
                  sectorAdvance <= !positioning;
                  setLst        <= !positioning && diskAddr.sector == `RP_SECTORS - 1;
               end

               default: state <= rpPkg::seqIdle;
            endcase
      end
   end

endmodule

// ==== verilog/rpErrors.sv ====
`timescale 1ns/1ns
`include "rp_consts.svh"

module rpErrors
(
   input  logic             clk,
   input  logic             rst,
   input  logic             clr,
   input  logic             drvClr,
   input  rpPkg::rpErrSet_t errSet,
   input  logic             rmr,
   output rpPkg::rpWord_t   er1
);

   rpPkg::rpWord_t setMask;
   logic           clearAll;

   ////////////////////////////////////////////////////////////
   // Set pulses mapped onto ER1 positions
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      setMask = '0;
      setMask[`RP_ER1_ILF] = errSet.ilf;
      // Refused writes come from the register file
      setMask[`RP_ER1_RMR] = rmr;
      setMask[`RP_ER1_IAE] = errSet.iae;
      setMask[`RP_ER1_WLE] = errSet.wle;
   end

   // Either clear beats a same-clock set
   assign clearAll = clr || drvClr;

   ////////////////////////////////////////////////////////////
   // Sticky ER1
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         er1 <= '0;
      else if (clearAll)
         er1 <= '0;
      else
         er1 <= er1 | setMask;
   end

endmodule

// ==== verilog/rpStatus.sv ====
`timescale 1ns/1ns
`include "rp_consts.svh"

module rpStatus
(
   input  logic            clk,
   input  logic            rst,
   input  logic            clr,
   input  logic            ataClr,
   input  logic            setLst,
   input  logic            setAta,
   input  rpPkg::rpMedia_t media,
   input  logic            pip,
   input  logic            dry,
   input  logic            drvClr,
   input  logic            volValid,
   input  logic            daWrite,
   input  rpPkg::rpWord_t  er1,
   output rpPkg::rpWord_t  ds
);

   logic dsAta;
   logic dsLst;
   logic dsVv;
   logic dsErr;

   ////////////////////////////////////////////////////////////
   // Sticky bits
   ////////////////////////////////////////////////////////////

   // Attention, cleared by AS write, drive clear or controller clear
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dsAta <= 1'b0;
      else if (clr || ataClr || drvClr)
         dsAta <= 1'b0;
      else if (setAta)
         dsAta <= 1'b1;
   end

   // Last sector, dropped by a new DA
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dsLst <= 1'b0;
      else if (clr || daWrite)
         dsLst <= 1'b0;
      else if (setLst)
         dsLst <= 1'b1;
   end

   // Volume valid, lost as soon as the pack goes away
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dsVv <= 1'b0;
      else if (clr || !media.cd)
         dsVv <= 1'b0;
      else if (volValid)
         dsVv <= 1'b1;
   end

   // Composite error, only ER1 here
   assign dsErr = er1 != '0;

   ////////////////////////////////////////////////////////////
   // Status word
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      ds = '0;
      ds[`RP_DS_ATA] = dsAta;
      ds[`RP_DS_ERR] = dsErr;
      ds[`RP_DS_PIP] = pip;
      ds[`RP_DS_MOL] = media.cd;
      ds[`RP_DS_WRL] = media.wp;
      ds[`RP_DS_LST] = dsLst;
      // Always programmable, always present
      ds[`RP_DS_PGM] = 1'b1;
      ds[`RP_DS_DPR] = 1'b1;
      ds[`RP_DS_DRY] = dry;
      ds[`RP_DS_VV]  = dsVv;
   end

endmodule

// ==== verilog/rpDrive.sv ====
`timescale 1ns/1ns

module rpDrive
(
   input  logic              clk,
   input  logic              rst,
   input  logic              clr,
   input  logic              wr,
   input  rpPkg::rpRegAddr_t wrAddr,
   input  rpPkg::rpWord_t    wrData,
   input  rpPkg::rpRegAddr_t rdAddr,
   output rpPkg::rpWord_t    rdData,
   input  rpPkg::rpMedia_t   media
);

   // Register file to sequencer
   rpPkg::rpCmd_t      cmd;
   rpPkg::rpDiskAddr_t diskAddr;

   // Sequencer levels and pulses
   logic               dry;
   logic               pip;
   logic               sectorAdvance;
   logic               addrClear;
   logic               setAta;
   logic               setLst;
   logic               drvClr;
   logic               volValid;
   rpPkg::rpErrSet_t   errSet;

   // Register file strobes
   logic               ataClr;
   logic               daWrite;
   logic               rmr;

   // Read-back words
   rpPkg::rpWord_t     er1;
   rpPkg::rpWord_t     ds;

   rpControl control_i
   (
      .clk           (clk),
      .rst           (rst),
      .clr           (clr),
      .wr            (wr),
      .wrAddr        (wrAddr),
      .wrData        (wrData),
      .rdAddr        (rdAddr),
      .dry           (dry),
      .sectorAdvance (sectorAdvance),
      .addrClear     (addrClear),
      .er1           (er1),
      .ds            (ds),
      .rdData        (rdData),
      .cmd           (cmd),
      .diskAddr      (diskAddr),
      .ataClr        (ataClr),
      .daWrite       (daWrite),
      .rmr           (rmr)
   );

   rpSequencer sequencer_i
   (
      .clk           (clk),
      .rst           (rst),
      .clr           (clr),
      .cmd           (cmd),
      .diskAddr      (diskAddr),
      .media         (media),
      .dry           (dry),
      .pip           (pip),
      .sectorAdvance (sectorAdvance),
      .addrClear     (addrClear),
      .setAta        (setAta),
      .setLst        (setLst),
      .drvClr        (drvClr),
      .volValid      (volValid),
      .errSet        (errSet)
   );

   rpErrors errors_i
   (
      .clk    (clk),
      .rst    (rst),
      .clr    (clr),
      .drvClr (drvClr),
      .errSet (errSet),
      .rmr    (rmr),
      .er1    (er1)
   );

   rpStatus status_i
   (
      .clk      (clk),
      .rst      (rst),
      .clr      (clr),
      .ataClr   (ataClr),
      .setLst   (setLst),
      .setAta   (setAta),
      .media    (media),
      .pip      (pip),
      .dry      (dry),
      .drvClr   (drvClr),
      .volValid (volValid),
      .daWrite  (daWrite),
      .er1      (er1),
      .ds       (ds)
   );

endmodule

// ==== sim/rpDrive_props.sv ====
`timescale 1ns/1ns

module rpDriveProps
(
   input logic             clk,
   input logic             rst,
   input logic             pip,
   input logic             dry,
   input logic             volValid,
   input rpPkg::rpMedia_t  media,
   input rpPkg::rpErrSet_t errPulses
);

   // Positioning means busy
   pipNotReady: assert property (@(posedge clk) disable iff (rst) pip |-> !dry)
      else $error("pip high while dry high");

   // Error set strobes never stretch
   errOneCycle: assert property (@(posedge clk) disable iff (rst)
      errPulses != '0 |=> errPulses == '0)
      else $error("error pulse longer than one clock");

   // No volume valid without a pack
   vvNeedsPack: assert property (@(posedge clk) disable iff (rst) volValid |-> media.cd)
      else $error("volValid raised while cd low");

endmodule

bind rpSequencer rpDriveProps seqProps_i
(
   .clk(clk), .rst(rst), .pip(pip), .dry(dry), .volValid(volValid),
   .media(media), .errPulses(errSet)
);

// ==== sim/rpDriveTb.sv ====
`timescale 1ns/1ns
`include "rp_consts.svh"

module rpDriveTb;

   localparam int HalfPeriod = 50;
   localparam int ReadyLimit = 200;

   logic              clk;
   logic              rst;
   logic              clr;
   logic              wr;
   rpPkg::rpRegAddr_t wrAddr;
   rpPkg::rpWord_t    wrData;
   rpPkg::rpRegAddr_t rdAddr;
   rpPkg::rpWord_t    rdData;
   rpPkg::rpMedia_t   media;

   int checks;
   int errors;
   int tests;
   int startChecks;
   int startErrors;

   rpDrive dut_i
   (
      .clk    (clk),
      .rst    (rst),
      .clr    (clr),
      .wr     (wr),
      .wrAddr (wrAddr),
      .wrData (wrData),
      .rdAddr (rdAddr),
      .rdData (rdData),
      .media  (media)
   );

   initial
   begin
      clk = 1'b0;
      forever #HalfPeriod clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Bus helpers, all driven from the falling edge
   ////////////////////////////////////////////////////////////

   function automatic logic [23:0] regName(input rpPkg::rpRegAddr_t a);
      case (a)
         `RP_CS1: return "CS1";
         `RP_DS:  return "DS ";
         `RP_ER1: return "ER1";
         `RP_AS:  return "AS ";
         `RP_DA:  return "DA ";
         `RP_DC:  return "DC ";
         default: return "???";
      endcase
   endfunction

   // One clock of wr, taken at the rising edge in between
   task automatic writeReg(input rpPkg::rpRegAddr_t a, input rpPkg::rpWord_t d);
      @(negedge clk);
      wr     = 1'b1;
      wrAddr = a;
      wrData = d;
      @(negedge clk);
      wr     = 1'b0;
   endtask

   // Read is combinational, sampled mid low phase
   task automatic checkReg(input rpPkg::rpRegAddr_t a, input rpPkg::rpWord_t mask,
                           input rpPkg::rpWord_t expected);
      rpPkg::rpWord_t got;
      @(negedge clk);
      rdAddr = a;
      #(HalfPeriod / 2);
      got    = rdData & mask;
      checks = checks + 1;
      if (got != (expected & mask))
      begin
         $display("Error at %0t ns: %s expected %h, got %h", $time, regName(a),
                  expected & mask, got);
         errors = errors + 1;
      end
   endtask

   task automatic setMedia(input logic cdLevel, input logic wpLevel);
      @(negedge clk);
      media.cd = cdLevel;
      media.wp = wpLevel;
   endtask

   task automatic pulseClear;
      @(negedge clk);
      clr = 1'b1;
      @(negedge clk);
      clr = 1'b0;
   endtask

   // Poll DS until the drive reports ready
   task automatic waitReady;
      int   polls;
      logic seen;
      polls = 0;
      seen  = 1'b0;
      while (!seen && polls < ReadyLimit)
      begin
         @(negedge clk);
         rdAddr = `RP_DS;
         #(HalfPeriod / 2);
         seen  = rdData[`RP_DS_DRY];
         polls = polls + 1;
      end
      checks = checks + 1;
      if (!seen)
      begin
         $display("Timeout: drive not ready within %0d clocks at %0t ns", ReadyLimit, $time);
         errors = errors + 1;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence, one file line per operation
   ////////////////////////////////////////////////////////////

   initial
   begin
      int              fd;
      int              code;
      int              testNum;
      logic            done;
      logic [7:0]      op;
      logic [31:0]     argA;
      logic [31:0]     argB;
      logic [31:0]     argC;
      logic [8*120-1:0] lineBuf;

      rst         = 1'b1;
      clr         = 1'b0;
      wr          = 1'b0;
      wrAddr      = '0;
      wrData      = '0;
      rdAddr      = '0;
      media       = '{cd: 1'b0, wp: 1'b0};
      checks      = 0;
      errors      = 0;
      tests       = 0;
      startChecks = 0;
      startErrors = 0;

      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      fd = $fopen("sim/rp_tests.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the test file sim/rp_tests.txt");
         errors = errors + 1;
      end
      else
      begin
         done = 1'b0;
         while (!done)
         begin
            code = $fscanf(fd, "%s", op);
            if (code != 1)
               done = 1'b1;
            else
               case (op)
                  // Comment line, skip the rest
                  "#": code = $fgets(lineBuf, fd);
                  "W":
                  begin
                     code = $fscanf(fd, "%h %h", argA, argB);
                     writeReg(argA[2:0], argB[15:0]);
                  end
                  "R":
                  begin
                     code = $fscanf(fd, "%h %h %h", argA, argB, argC);
                     checkReg(argA[2:0], argB[15:0], argC[15:0]);
                  end
                  "M":
                  begin
                     code = $fscanf(fd, "%h %h", argA, argB);
                     setMedia(argA[0], argB[0]);
                  end
                  "C": pulseClear();
                  "Y": waitReady();
                  "E":
                  begin
                     code  = $fscanf(fd, "%d", testNum);
                     tests = tests + 1;
                     $display("Test %0d finished: %0d checks, %0d errors", testNum,
                              checks - startChecks, errors - startErrors);
                     startChecks = checks;
                     startErrors = errors;
                  end
                  default:
                  begin
                     $display("Unknown operation in the test file, reading stopped");
                     errors = errors + 1;
                     done   = 1'b1;
                  end
               endcase
         end
         $fclose(fd);
      end

      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// ==== sim/rp_tests.txt ====
# Columns: op then hex fields. W addr data, R addr mask expect, M cd wp,
# C pulses clr, Y waits for ready, E ends a test and gives its number
M 1 0
R 1 FFFF 1380
R 2 FFFF 0000
R 3 FFFF 0000
E 1
W 0 0013
R 1 FFFF 13C0
M 0 0
R 1 FFFF 0380
M 1 0
W 4 0305
W 5 0010
R 4 FFFF 0305
W 0 0011
R 4 FFFF 0000
R 5 FFFF 0000
R 1 FFFF 13C0
E 2
W 5 0064
W 4 0A07
W 0 0005
R 1 2080 2000
Y
R 1 FFFF 93C0
R 3 FFFF 0001
W 3 0001
R 1 FFFF 13C0
E 3
W 4 0014
W 0 0005
R 2 FFFF 0400
R 1 FFFF D3C0
W 0 0003
R 2 FFFF 0401
W 0 0009
R 2 FFFF 0000
R 1 FFFF 13C0
E 4
W 4 0413
W 0 0039
Y
R 1 FFFF 17C0
R 4 FFFF 0500
W 4 0502
R 1 FFFF 13C0
M 1 1
W 0 0031
R 2 FFFF 0800
R 1 FFFF DBC0
R 4 FFFF 0502
E 5
M 1 0
W 0 0005
W 4 0107
Y
R 2 FFFF 0804
R 4 FFFF 0502
R 1 FFFF D3C0
C
R 1 FFFF 1380
R 2 FFFF 0000
E 6

// ==== project.f ====
+incdir+include
verilog/rpPkg.sv
verilog/rpControl.sv
verilog/rpSequencer.sv
verilog/rpErrors.sv
verilog/rpStatus.sv
verilog/rpDrive.sv
sim/rpDrive_props.sv
sim/rpDriveTb.sv
